// File: compile.f
src/wh_router_pkg.sv
src/wh_two_fifo.sv
src/wh_dor_decoder.sv
src/wh_input_control.sv
src/wh_output_control.sv
src/wh_router.sv
tb/tb_wh_router.sv

// File: tb/tb_wh_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wh_router;

  localparam int dirs_c      = wh_router_pkg::dirs_c;
  localparam int num_pkts_c  = 21;
  localparam int num_tests_c = 5;
  localparam int stall_test  = 5;
  localparam int my_x_c      = 2;
  localparam int my_y_c      = 2;
  localparam int seed_c      = 58381;

  localparam int p_port = wh_router_pkg::dir_p_c;
  localparam int w_port = wh_router_pkg::dir_w_c;
  localparam int e_port = wh_router_pkg::dir_e_c;
  localparam int n_port = wh_router_pkg::dir_n_c;
  localparam int s_port = wh_router_pkg::dir_s_c;

  typedef struct packed {
    logic [3:0] test_id;
    logic [2:0] src;
    logic [3:0] dx;
    logic [3:0] dy;
    logic [3:0] len;
    logic [7:0] start;
    logic       bp;
  } pkt_t;

  // test, source, dest x, dest y, body length, start cycle, back-pressure
  pkt_t pkt_tbl [num_pkts_c] = '{
    '{1, p_port, 3, 2, 0, 0, 0}, '{1, w_port, 2, 1, 0, 0, 0}, '{1, e_port, 2, 2, 0, 0, 0},
    '{1, n_port, 2, 3, 0, 0, 0}, '{1, s_port, 1, 2, 0, 0, 0},
    '{2, p_port, 0, 0, 3, 0, 0}, '{2, w_port, 5, 1, 2, 0, 0}, '{2, e_port, 2, 0, 4, 0, 0},
    '{2, n_port, 2, 2, 1, 0, 0}, '{2, s_port, 2, 6, 5, 0, 0}, '{2, w_port, 2, 2, 2, 4, 0},
    '{3, w_port, 4, 2, 3, 0, 0}, '{3, n_port, 6, 0, 2, 0, 0}, '{3, p_port, 3, 5, 0, 1, 0},
    '{3, s_port, 2, 2, 2, 0, 0},
    '{4, w_port, 5, 2, 4, 0, 1}, '{4, s_port, 0, 3, 3, 0, 1}, '{4, e_port, 2, 2, 2, 0, 1},
    '{4, p_port, 2, 0, 5, 0, 1}, '{4, n_port, 7, 9, 3, 2, 1},
    '{5, w_port, 3, 2, 3, 2, 0}
  };

  string test_name [num_tests_c+1] = '{"reset", "single flit", "multi flit", "contention",
                                       "back-pressure", "stall"};

  logic                           clk_i;
  logic                           arst_n_i;
  logic [dirs_c-1:0]              link_v_i;
  logic [dirs_c-1:0][31:0]        link_data_i;
  logic [dirs_c-1:0]              link_ready_o;
  logic [dirs_c-1:0]              link_v_o;
  logic [dirs_c-1:0][31:0]        link_data_o;
  logic [dirs_c-1:0]              link_ready_i;
  logic [3:0]                     my_x_i;
  logic [3:0]                     my_y_i;

  // source flits waiting to be sent and packets expected per output
  logic [31:0] src_q [dirs_c][$];
  int          pend [dirs_c][$];
  int          cur_pkt [dirs_c];
  int          cur_idx [dirs_c];
  int          acc_cnt [dirs_c];
  bit          held_v [dirs_c];
  logic [31:0] held_d [dirs_c];
  bit [dirs_c-1:0] bp_mask;
  bit          stall_all;
  int          err_cnt;
  int          pkts_done;
  int          tests_failed;

  wh_router
    #(.flit_width_p(32)
     ,.x_cord_width_p(4)
     ,.y_cord_width_p(4)
     ,.len_width_p(4)
     ) i_dut
    (.clk_i       (clk_i)
    ,.arst_n_i    (arst_n_i)
    ,.link_v_i    (link_v_i)
    ,.link_data_i (link_data_i)
    ,.link_ready_o(link_ready_o)
    ,.link_v_o    (link_v_o)
    ,.link_data_o (link_data_o)
    ,.link_ready_i(link_ready_i)
    ,.my_x_i      (my_x_i)
    ,.my_y_i      (my_y_i)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // XY order resolves x first and then y
  // a match in both goes to the local port
  function automatic int xy_port(input int dx, input int dy);
    if (dx > my_x_c)
      return e_port;
    else if (dx < my_x_c)
      return w_port;
    else if (dy > my_y_c)
      return s_port;
    else if (dy < my_y_c)
      return n_port;
    return p_port;
  endfunction

  function automatic logic [31:0] hdr_flit(input int id);
    return {4'hA, 8'(id), 8'h00, pkt_tbl[id].len, pkt_tbl[id].dy, pkt_tbl[id].dx};
  endfunction

  function automatic logic [31:0] body_flit(input int id, input int idx);
    return {4'hB, 8'(id), 12'h000, 8'(idx)};
  endfunction

  function automatic bit drained();
    bit ok;
    ok = 1'b1;
    for (int k = 0; k < dirs_c; k++)
      if (src_q[k].size() != 0 || pend[k].size() != 0 || cur_pkt[k] >= 0)
        ok = 1'b0;
    return ok;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic note_error(input string msg);
    $display("error: %s", msg);
    err_cnt++;
  endtask

  task automatic load_packet(input int id);
    src_q[pkt_tbl[id].src].push_back(hdr_flit(id));
    for (int b = 1; b <= int'(pkt_tbl[id].len); b++)
      src_q[pkt_tbl[id].src].push_back(body_flit(id, b));
    pend[xy_port(pkt_tbl[id].dx, pkt_tbl[id].dy)].push_back(id);
  endtask

  // a header may belong to any packet pending on that port
  // the body must follow its own header
  task automatic take_flit(input int j, input logic [31:0] flit);
    int    k;
    string name;
    name = $sformatf("link_data_o[%0d]", j);
    if (cur_pkt[j] < 0)
    begin
      k = -1;
      for (int n = 0; n < pend[j].size(); n++)
        if (hdr_flit(pend[j][n]) == flit)
          k = n;
      if (k >= 0)
      begin
        if (pkt_tbl[pend[j][k]].len == 0)
          pkts_done++;
        else
        begin
          cur_pkt[j] = pend[j][k];
          cur_idx[j] = 0;
        end
        pend[j].delete(k);
      end
      else if (pend[j].size() > 0)
        check(name, flit, hdr_flit(pend[j][0]));
      else
        note_error($sformatf("flit 0x%08h left port %0d with no packet due there", flit, j));
    end
    else
    begin
      cur_idx[j]++;
      check(name, flit, body_flit(cur_pkt[j], cur_idx[j]));
      if (cur_idx[j] == int'(pkt_tbl[cur_pkt[j]].len))
      begin
        pkts_done++;
        cur_pkt[j] = -1;
      end
    end
  endtask

  // sample the outputs of one clock and then drive the next inputs
  task automatic run_cycle();
    @(posedge clk_i);
    for (int j = 0; j < dirs_c; j++)
    begin
      // a stalled flit must stay on the link unchanged
      if (held_v[j])
      begin
        check($sformatf("link_v_o[%0d]", j), 32'(link_v_o[j]), 32'h1);
        check($sformatf("link_data_o[%0d]", j), link_data_o[j], held_d[j]);
      end
      held_v[j] = link_v_o[j] & ~link_ready_i[j];
      held_d[j] = link_data_o[j];
      if (link_v_o[j] & link_ready_i[j])
        take_flit(j, link_data_o[j]);
    end
    for (int p = 0; p < dirs_c; p++)
    begin
      if (link_v_i[p] & link_ready_o[p])
      begin
        void'(src_q[p].pop_front());
        acc_cnt[p]++;
      end
      if (src_q[p].size() > 0)
      begin
        link_v_i[p]    <= 1'b1;
        link_data_i[p] <= src_q[p][0];
      end
      else
        link_v_i[p] <= 1'b0;
      if (stall_all)
        link_ready_i[p] <= 1'b0;
      else if (bp_mask[p])
        link_ready_i[p] <= (($urandom % 4) != 0);
      else
        link_ready_i[p] <= 1'b1;
    end
  endtask

  task automatic report_test(input int t, input int err0);
    if (err_cnt == err0)
      $display("test %0d %s: ok", t, test_name[t]);
    else
    begin
      $display("test %0d %s: %0d errors", t, test_name[t], err_cnt - err0);
      tests_failed++;
    end
  endtask

  initial
  begin
    int rel;
    int max_start;
    int err0;
    int stall_src;
    int stall_acc0;
    int stall_wait;
    bit busy;
    void'($urandom(seed_c));
    arst_n_i     = 1'b0;
    link_v_i     = '0;
    link_data_i  = '0;
    link_ready_i = '1;
    my_x_i       = 4'(my_x_c);
    my_y_i       = 4'(my_y_c);
    stall_all    = 1'b0;
    bp_mask      = '0;
    err_cnt      = 0;
    pkts_done    = 0;
    tests_failed = 0;
    stall_src    = 0;
    for (int k = 0; k < dirs_c; k++)
    begin
      cur_pkt[k] = -1;
      cur_idx[k] = 0;
      acc_cnt[k] = 0;
      held_v[k]  = 1'b0;
      held_d[k]  = '0;
    end
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;

    err0 = err_cnt;
    run_cycle();
    check("link_v_o", 32'(link_v_o), 32'h0);
    check("link_ready_o", 32'(link_ready_o), 32'h1f);
    report_test(0, err0);

    for (int t = 1; t <= num_tests_c; t++)
    begin
      err0       = err_cnt;
      rel        = 0;
      max_start  = 0;
      stall_wait = 0;
      bp_mask    = '0;
      for (int e = 0; e < num_pkts_c; e++)
        if (pkt_tbl[e].test_id == t)
        begin
          if (pkt_tbl[e].start > max_start)
            max_start = pkt_tbl[e].start;
          if (pkt_tbl[e].bp)
            bp_mask[xy_port(pkt_tbl[e].dx, pkt_tbl[e].dy)] = 1'b1;
          if (t == stall_test)
            stall_src = pkt_tbl[e].src;
        end
      stall_all  = (t == stall_test);
      stall_acc0 = acc_cnt[stall_src];
      busy       = 1'b1;
      while (busy)
      begin
        for (int e = 0; e < num_pkts_c; e++)
          if (pkt_tbl[e].test_id == t && pkt_tbl[e].start == rel)
            load_packet(e);
        run_cycle();
        rel++;
        // two flits fill the input FIFO and the link must then refuse more
        if (stall_all && acc_cnt[stall_src] >= stall_acc0 + 2)
        begin
          stall_wait++;
          if (stall_wait == 3)
          begin
            check($sformatf("link_ready_o[%0d]", stall_src),
                  32'(link_ready_o[stall_src]), 32'h0);
            if (acc_cnt[stall_src] != stall_acc0 + 2)
              note_error("input accepted a third flit while all outputs were stalled");
            stall_all = 1'b0;
          end
        end
        busy = stall_all || (rel <= max_start) || !drained();
      end
      repeat (3) run_cycle();
      if (t == stall_test)
        check($sformatf("link_ready_o[%0d]", stall_src), 32'(link_ready_o[stall_src]), 32'h1);
      report_test(t, err0);
    end

    $display("%0d tests, %0d failed, %0d packets delivered, %0d errors",
             num_tests_c + 1, tests_failed, pkts_done, err_cnt);
    if (err_cnt == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

  // limit scales with the number of flits in the table
  initial
  begin
    int limit;
    limit = 200;
    for (int e = 0; e < num_pkts_c; e++)
      limit += (int'(pkt_tbl[e].len) + 1) * 20;
    repeat (limit) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", limit);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/wh_router.sv
`timescale 1ns/1ps
`default_nettype none

module wh_router
  #(parameter int flit_width_p   = 32
   ,parameter int x_cord_width_p = 4
   ,parameter int y_cord_width_p = 4
   ,parameter int len_width_p    = 4
   )
  (input  logic                                               clk_i
  ,input  logic                                               arst_n_i

  // receive side, one link per direction
  ,input  logic [wh_router_pkg::dirs_c-1:0]                   link_v_i
  ,input  logic [wh_router_pkg::dirs_c-1:0][flit_width_p-1:0] link_data_i
  ,output logic [wh_router_pkg::dirs_c-1:0]                   link_ready_o

  // send side
  ,output logic [wh_router_pkg::dirs_c-1:0]                   link_v_o
  ,output logic [wh_router_pkg::dirs_c-1:0][flit_width_p-1:0] link_data_o
  ,input  logic [wh_router_pkg::dirs_c-1:0]                   link_ready_i

  ,input  logic [x_cord_width_p-1:0]                          my_x_i
  ,input  logic [y_cord_width_p-1:0]                          my_y_i
  );

  localparam int dirs_lp = wh_router_pkg::dirs_c;

  // header field positions inside a flit
  localparam int y_pos_lp   = x_cord_width_p;
  localparam int len_pos_lp = x_cord_width_p + y_cord_width_p;

  logic [dirs_lp-1:0][flit_width_p-1:0] fifo_data;
  logic [dirs_lp-1:0]                   fifo_v;
  logic [dirs_lp-1:0]                   releases;
  logic [dirs_lp-1:0]                   any_yumi;

  // reqs is indexed [input][output], yumis is indexed [output][input]
  logic [dirs_lp-1:0][dirs_lp-1:0]      reqs;
  logic [dirs_lp-1:0][dirs_lp-1:0]      reqs_t;
  logic [dirs_lp-1:0][dirs_lp-1:0]      yumis;
  logic [dirs_lp-1:0][dirs_lp-1:0]      yumis_t;

  for (genvar i = 0; i < dirs_lp; i++)
  begin : in_ch
    logic [dirs_lp-1:0] decoded_dest;

    assign any_yumi[i] = |yumis_t[i];

    wh_two_fifo #(.width_p(flit_width_p)) i_fifo
      (.clk_i   (clk_i)
      ,.arst_n_i(arst_n_i)
      ,.v_i     (link_v_i[i])
      ,.data_i  (link_data_i[i])
      ,.ready_o (link_ready_o[i])
      ,.v_o     (fifo_v[i])
      ,.data_o  (fifo_data[i])
      ,.yumi_i  (any_yumi[i])
      );

    // decoded every cycle, only meaningful while a header sits at the head
    wh_dor_decoder
      #(.x_cord_width_p(x_cord_width_p)
       ,.y_cord_width_p(y_cord_width_p)
       ) i_dor
      (.target_x_i(fifo_data[i][0 +: x_cord_width_p])
      ,.target_y_i(fifo_data[i][y_pos_lp +: y_cord_width_p])
      ,.my_x_i    (my_x_i)
      ,.my_y_i    (my_y_i)
      ,.req_o     (decoded_dest)
      );

    wh_input_control #(.len_width_p(len_width_p)) i_ctrl
      (.clk_i         (clk_i)
      ,.arst_n_i      (arst_n_i)
      ,.fifo_v_i      (fifo_v[i])
      ,.fifo_yumi_i   (any_yumi[i])
      ,.decoded_dest_i(decoded_dest)
      ,.payload_len_i (fifo_data[i][len_pos_lp +: len_width_p])
      ,.reqs_o        (reqs[i])
      ,.release_o     (releases[i])
      );
  end

  // swap input and output indexing between the two sides
  for (genvar i = 0; i < dirs_lp; i++)
  begin : xpose_row
    for (genvar j = 0; j < dirs_lp; j++)
    begin : xpose_col
      assign reqs_t[j][i]  = reqs[i][j];
      assign yumis_t[i][j] = yumis[j][i];
    end
  end

  for (genvar j = 0; j < dirs_lp; j++)
  begin : out_ch
    logic [dirs_lp-1:0]      data_sel;
    logic [flit_width_p-1:0] mux_data;

    wh_output_control i_ctrl
      (.clk_i     (clk_i)
      ,.arst_n_i  (arst_n_i)
      ,.reqs_i    (reqs_t[j])
      ,.release_i (releases)
      ,.valid_i   (fifo_v)
      ,.ready_i   (link_ready_i[j])
      ,.yumi_o    (yumis[j])
      ,.valid_o   (link_v_o[j])
      ,.data_sel_o(data_sel)
      );

    // one-hot and-or over the fifo heads
    always_comb
    begin
      mux_data = '0;
      for (int i = 0; i < dirs_lp; i++)
        mux_data = mux_data | (fifo_data[i] & {flit_width_p{data_sel[i]}});
    end

    assign link_data_o[j] = mux_data;
  end

endmodule

`default_nettype wire

// File: src/wh_output_control.sv
`timescale 1ns/1ps
`default_nettype none

module wh_output_control
  (input  logic                             clk_i
  ,input  logic                             arst_n_i
  ,input  logic [wh_router_pkg::dirs_c-1:0] reqs_i
  ,input  logic [wh_router_pkg::dirs_c-1:0] release_i
  ,input  logic [wh_router_pkg::dirs_c-1:0] valid_i
  ,input  logic                             ready_i
  ,output logic [wh_router_pkg::dirs_c-1:0] yumi_o
  ,output logic                             valid_o
  ,output logic [wh_router_pkg::dirs_c-1:0] data_sel_o
  );

  localparam int ptr_w_lp = $clog2(wh_router_pkg::dirs_c);

  logic                             locked_r;
  logic [wh_router_pkg::dirs_c-1:0] owner_r;
  logic [ptr_w_lp-1:0]              ptr_r;
  logic [wh_router_pkg::dirs_c-1:0] grant;
  logic [ptr_w_lp-1:0]              win_idx;
  logic [ptr_w_lp-1:0]              ptr_next;
  logic [wh_router_pkg::dirs_c-1:0] sel;
  logic                             xfer;

  // round robin search, starting at the pointer and wrapping
  always_comb
  begin
    int  idx;
    logic found;
    grant   = '0;
    win_idx = '0;
    found   = 1'b0;
    for (int k = 0; k < wh_router_pkg::dirs_c; k++)
    begin
      idx = int'(ptr_r) + k;
      if (idx >= wh_router_pkg::dirs_c)
        idx = idx - wh_router_pkg::dirs_c;
      if (!found && reqs_i[idx])
      begin
        grant[idx] = 1'b1;
        win_idx    = ptr_w_lp'(idx);
        found      = 1'b1;
      end
    end
  end

  // next search starts just past the winner
  assign ptr_next = (win_idx == ptr_w_lp'(wh_router_pkg::dirs_c - 1))
                  ? '0 : win_idx + ptr_w_lp'(1);

  // a fresh grant drives the link in the same cycle
  assign sel        = locked_r ? owner_r : grant;
  assign data_sel_o = sel;
  assign valid_o    = |(sel & valid_i);
  assign xfer       = valid_o & ready_i;
  assign yumi_o     = sel & {wh_router_pkg::dirs_c{xfer}};

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      locked_r <= 1'b0;
      owner_r  <= '0;
      ptr_r    <= '0;
    end
    else if (locked_r)
    begin
      // only the owner can end the packet on this output
      if (|(owner_r & release_i))
        locked_r <= 1'b0;
    end
    else if (|grant)
    begin
      // a header-only packet that leaves at once does not hold the output
      locked_r <= ~|(grant & release_i);
      owner_r  <= grant;
      ptr_r    <= ptr_next;
    end
  end

endmodule

`default_nettype wire

// File: src/wh_input_control.sv
`timescale 1ns/1ps
`default_nettype none

module wh_input_control
  #(parameter int len_width_p = 4)
  (input  logic                             clk_i
  ,input  logic                             arst_n_i
  ,input  logic                             fifo_v_i
  ,input  logic                             fifo_yumi_i
  ,input  logic [wh_router_pkg::dirs_c-1:0] decoded_dest_i
  ,input  logic [len_width_p-1:0]           payload_len_i
  ,output logic [wh_router_pkg::dirs_c-1:0] reqs_o
  ,output logic                             release_o
  );

  logic                             hdr_exp_r;
  logic [len_width_p-1:0]           cnt_r;
  logic [wh_router_pkg::dirs_c-1:0] held_r;
  logic                             last_body;

  // body flits left after this one
  assign last_body = (cnt_r == len_width_p'(1));

  // the header asks live, the body keeps asking even with an empty fifo
  assign reqs_o = hdr_exp_r ? (fifo_v_i ? decoded_dest_i : '0) : held_r;

  // a zero length header ends its packet by itself
  assign release_o = fifo_yumi_i
                   & (hdr_exp_r ? (payload_len_i == '0) : last_body);

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      hdr_exp_r <= 1'b1;
      cnt_r     <= '0;
      held_r    <= '0;
    end
    else if (fifo_yumi_i)
    begin
      if (hdr_exp_r)
      begin
        if (payload_len_i != '0)
        begin
          hdr_exp_r <= 1'b0;
          cnt_r     <= payload_len_i;
          held_r    <= decoded_dest_i;
        end
      end
      else
      begin
        cnt_r <= cnt_r - len_width_p'(1);
        if (last_body)
        begin
          hdr_exp_r <= 1'b1;
          held_r    <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: src/wh_dor_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wh_dor_decoder
  #(parameter int x_cord_width_p = 4
   ,parameter int y_cord_width_p = 4
   )
  (input  logic [x_cord_width_p-1:0]         target_x_i
  ,input  logic [y_cord_width_p-1:0]         target_y_i
  ,input  logic [x_cord_width_p-1:0]         my_x_i
  ,input  logic [y_cord_width_p-1:0]         my_y_i
  ,output logic [wh_router_pkg::dirs_c-1:0]  req_o
  );

  logic x_gt;
  logic x_lt;
  logic y_gt;
  logic y_lt;

  assign x_gt = (target_x_i > my_x_i);
  assign x_lt = (target_x_i < my_x_i);
  assign y_gt = (target_y_i > my_y_i);
  assign y_lt = (target_y_i < my_y_i);

  // x is resolved first, y only once the column matches
  always_comb
  begin
    req_o = '0;
    if (x_gt)
      req_o[wh_router_pkg::dir_e_c] = 1'b1;
    else if (x_lt)
      req_o[wh_router_pkg::dir_w_c] = 1'b1;
    else if (y_gt)
      req_o[wh_router_pkg::dir_s_c] = 1'b1;
    else if (y_lt)
      req_o[wh_router_pkg::dir_n_c] = 1'b1;
    else
      // arrived, hand it to the local processor
      req_o[wh_router_pkg::dir_p_c] = 1'b1;
  end

endmodule

`default_nettype wire

// File: src/wh_two_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module wh_two_fifo
  #(parameter int width_p = 32)
  (input  logic               clk_i
  ,input  logic               arst_n_i
  ,input  logic               v_i
  ,input  logic [width_p-1:0] data_i
  ,output logic               ready_o
  ,output logic               v_o
  ,output logic [width_p-1:0] data_o
  ,input  logic               yumi_i
  );

  logic [width_p-1:0] mem_r [2];
  logic               wptr_r;
  logic               rptr_r;
  logic               full_r;
  logic               empty_r;
  logic               enq;
  logic               deq;

  // ready is registered, so the link never sees a path from the far side
  assign ready_o = ~full_r;
  assign v_o     = ~empty_r;
  assign data_o  = mem_r[rptr_r];

  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  always_ff @(posedge clk_i or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wptr_r  <= 1'b0;
      rptr_r  <= 1'b0;
      full_r  <= 1'b0;
      empty_r <= 1'b1;
    end
    else
    begin
      if (enq)
        wptr_r <= ~wptr_r;
      if (deq)
        rptr_r <= ~rptr_r;
      // occupancy only moves when exactly one side is active
      if (enq & ~deq)
      begin
        empty_r <= 1'b0;
        full_r  <= (~wptr_r == rptr_r);
      end
      else if (deq & ~enq)
      begin
        full_r  <= 1'b0;
        empty_r <= (~rptr_r == wptr_r);
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (enq)
      mem_r[wptr_r] <= data_i;
  end

endmodule

`default_nettype wire

// File: src/wh_router_pkg.sv
`default_nettype none

package wh_router_pkg;

  // number of router ports, processor plus the four mesh neighbours
  localparam int dirs_c = 5;

  // port indices
  // each one selects a bit of the five-bit request, yumi and select vectors

  // local processor, also the target of a header addressed to this router
  localparam int dir_p_c = 0;

  // x dimension, west is the smaller coordinate
  localparam int dir_w_c = 1;
  localparam int dir_e_c = 2;

  // y dimension, north is the smaller coordinate
  localparam int dir_n_c = 3;
  localparam int dir_s_c = 4;

endpackage

`default_nettype wire
